/* include/periph_params.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory map and sizing macros for the minimal peripheral block.
// Include wherever bus widths, block offsets or the window base
// are needed.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// bus widths and window base
`define PERIPH_WORD   8
`define PERIPH_ADDR_W 8
`define PERIPH_BASE   8'hEE

// registers per block
`define EXTI_SIZE  2
`define GPIO_SIZE  4
`define TIMER_SIZE 3
`define UART_SIZE  3

// block offsets inside the window
`define EXTI_OFF  0
`define GPIO_OFF  2
`define TIMER_OFF 6
`define UART_OFF  9

`define PERIPH_TOTAL 12
`define PERIPH_OFF_W 4

// baud divisor after reset, cycles per bit minus one
`define UART_DIV_RESET 4

`endif

/* rtl/periph_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the peripheral block: the interrupt flag byte and
// the register position inside a block. Import into module bodies.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "periph_params.svh"

package periph_pkg;

    // one flag byte, seen either as a bus word or as named sources
    typedef union packed {
        logic [`PERIPH_WORD-1:0] raw;
        struct packed {
            logic [`PERIPH_WORD-4:0] unused;
            logic                    uart;
            logic                    timer;
            logic                    gpio;
        } src;
    } irq_flags_u;

    // position of a register inside its own block
    typedef enum logic [1:0] {
        REG_0 = 2'd0,
        REG_1 = 2'd1,
        REG_2 = 2'd2,
        REG_3 = 2'd3
    } reg_sel_e;

endpackage

`default_nettype wire

/* rtl/periph_bus_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded register access from the top level to each peripheral.
// The top drives the master side, peripherals take the other one.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

interface periph_bus_if;

    // access falls inside the window and the bus is enabled
    logic                     sel;
    logic [`PERIPH_OFF_W-1:0] offset;
    logic [`PERIPH_WORD-1:0]  wdata;
    logic                     write_en;

    modport master (output sel, output offset, output wdata, output write_en);

    modport peripheral (input sel, input offset, input wdata, input write_en);

endinterface

`default_nettype wire

/* rtl/periph_exti.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Interrupt controller. Latches one-cycle pulses from the gpio, timer
// and uart blocks and drives the masked CPU interrupt lines.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module periph_exti (
    input  logic                    clk,
    input  logic                    rst_n,
    periph_bus_if.peripheral        bus,
    output logic [`PERIPH_WORD-1:0] rdata,
    input  logic                    gpio_irq,
    input  logic                    timer_irq,
    input  logic                    uart_irq,
    output logic [2:0]              ext_int
);
    import periph_pkg::*;

    localparam logic [`PERIPH_OFF_W-1:0] BLK_OFF = `EXTI_OFF;
    localparam logic [`PERIPH_OFF_W-1:0] BLK_END = `EXTI_OFF + `EXTI_SIZE;

    logic                     hit;
    logic                     wr;
    logic [`PERIPH_OFF_W-1:0] rel;
    reg_sel_e                 reg_sel;
    logic [2:0]               mask_q;
    irq_flags_u               pend_q;
    irq_flags_u               set_v;
    irq_flags_u               clr_v;

    assign hit     = bus.sel && (bus.offset >= BLK_OFF) && (bus.offset < BLK_END);
    assign wr      = hit && bus.write_en;
    assign rel     = bus.offset - BLK_OFF;
    assign reg_sel = reg_sel_e'(rel[1:0]);

    always_comb
    begin
        set_v.raw       = '0;
        set_v.src.gpio  = gpio_irq;
        set_v.src.timer = timer_irq;
        set_v.src.uart  = uart_irq;
        // write 1 to clear
        clr_v.raw = (wr && reg_sel == REG_1) ? bus.wdata : '0;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mask_q     <= '0;
            pend_q.raw <= '0;
        end
        else
        begin
            if (wr && reg_sel == REG_0)
                mask_q <= bus.wdata[2:0];
            // a new pulse beats a clear in the same cycle
            pend_q.raw <= set_v.raw | (pend_q.raw & ~clr_v.raw);
        end
    end

    assign ext_int = {pend_q.src.uart, pend_q.src.timer, pend_q.src.gpio} & mask_q;

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (reg_sel)
                REG_0:   rdata[2:0] = mask_q;
                REG_1:   rdata      = pend_q.raw;
                default: rdata      = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/periph_gpio.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 16-bit GPIO port: byte-written output latch, two-flop synchronized
// input and a one-cycle pulse whenever a synchronized input changes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module periph_gpio (
    input  logic                    clk,
    input  logic                    rst_n,
    periph_bus_if.peripheral        bus,
    output logic [`PERIPH_WORD-1:0] rdata,
    output logic                    irq,
    input  logic [15:0]             gpi,
    output logic [15:0]             gpo
);
    import periph_pkg::*;

    localparam logic [`PERIPH_OFF_W-1:0] BLK_OFF = `GPIO_OFF;
    localparam logic [`PERIPH_OFF_W-1:0] BLK_END = `GPIO_OFF + `GPIO_SIZE;

    logic                     hit;
    logic                     wr;
    logic [`PERIPH_OFF_W-1:0] rel;
    reg_sel_e                 reg_sel;
    logic [15:0]              gpi_s1;
    logic [15:0]              gpi_s2;
    logic [15:0]              gpi_prev;

    assign hit     = bus.sel && (bus.offset >= BLK_OFF) && (bus.offset < BLK_END);
    assign wr      = hit && bus.write_en;
    assign rel     = bus.offset - BLK_OFF;
    assign reg_sel = reg_sel_e'(rel[1:0]);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            gpo      <= '0;
            gpi_s1   <= '0;
            gpi_s2   <= '0;
            gpi_prev <= '0;
        end
        else
        begin
            if (wr && reg_sel == REG_0)
                gpo[7:0] <= bus.wdata;
            if (wr && reg_sel == REG_1)
                gpo[15:8] <= bus.wdata;
            gpi_s1   <= gpi;
            gpi_s2   <= gpi_s1;
            gpi_prev <= gpi_s2;
        end
    end

    // high for one cycle after the synchronizer picks up a change
    assign irq = |(gpi_s2 ^ gpi_prev);

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (reg_sel)
                REG_0: rdata = gpo[7:0];
                REG_1: rdata = gpo[15:8];
                REG_2: rdata = gpi_s2[7:0];
                REG_3: rdata = gpi_s2[15:8];
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/periph_timer.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reload down-counter behind a prescaler. While running it pulses irq
// once every (reload+1)*(prescale+1) cycles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module periph_timer (
    input  logic                    clk,
    input  logic                    rst_n,
    periph_bus_if.peripheral        bus,
    output logic [`PERIPH_WORD-1:0] rdata,
    output logic                    irq
);
    import periph_pkg::*;

    localparam logic [`PERIPH_OFF_W-1:0] BLK_OFF = `TIMER_OFF;
    localparam logic [`PERIPH_OFF_W-1:0] BLK_END = `TIMER_OFF + `TIMER_SIZE;

    logic                     hit;
    logic                     wr;
    logic [`PERIPH_OFF_W-1:0] rel;
    reg_sel_e                 reg_sel;
    logic [`PERIPH_WORD-1:0]  reload_q;
    logic [`PERIPH_WORD-1:0]  presc_q;
    logic                     run_q;
    logic [`PERIPH_WORD-1:0]  presc_cnt;
    logic [`PERIPH_WORD-1:0]  count;
    logic                     tick;

    assign hit     = bus.sel && (bus.offset >= BLK_OFF) && (bus.offset < BLK_END);
    assign wr      = hit && bus.write_en;
    assign rel     = bus.offset - BLK_OFF;
    assign reg_sel = reg_sel_e'(rel[1:0]);

    // one tick per prescale period
    assign tick = run_q && (presc_cnt == '0);
    assign irq  = tick && (count == '0);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            reload_q  <= '0;
            presc_q   <= '0;
            run_q     <= 1'b0;
            presc_cnt <= '0;
            count     <= '0;
        end
        else
        begin
            if (wr && reg_sel == REG_0)
                reload_q <= bus.wdata;
            if (wr && reg_sel == REG_1)
                presc_q <= bus.wdata;
            if (wr && reg_sel == REG_2)
            begin
                // restart from a clean period
                run_q     <= bus.wdata[0];
                presc_cnt <= presc_q;
                count     <= reload_q;
            end
            else if (run_q)
            begin
                presc_cnt <= tick ? presc_q : presc_cnt - 1'b1;
                if (tick)
                    count <= (count == '0) ? reload_q : count - 1'b1;
            end
        end
    end

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (reg_sel)
                REG_0:   rdata    = reload_q;
                REG_1:   rdata    = presc_q;
                REG_2:   rdata[0] = run_q;
                default: rdata    = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/periph_uart.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 UART. Bit time is (divisor+1) clocks, set through a register.
// Writing data starts a frame; a received byte raises rx_valid and irq.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module periph_uart (
    input  logic                    clk,
    input  logic                    rst_n,
    periph_bus_if.peripheral        bus,
    output logic [`PERIPH_WORD-1:0] rdata,
    output logic                    irq,
    input  logic                    rx,
    output logic                    tx
);
    import periph_pkg::*;

    localparam logic [`PERIPH_OFF_W-1:0] BLK_OFF = `UART_OFF;
    localparam logic [`PERIPH_OFF_W-1:0] BLK_END = `UART_OFF + `UART_SIZE;

    logic                     hit;
    logic                     wr;
    logic [`PERIPH_OFF_W-1:0] rel;
    reg_sel_e                 reg_sel;
    logic [`PERIPH_WORD-1:0]  div_q;
    logic                     tx_busy;
    logic [9:0]               tx_shift;
    logic [3:0]               tx_bits;
    logic [`PERIPH_WORD-1:0]  tx_cnt;
    logic                     rx_s1;
    logic                     rx_s2;
    logic                     rx_prev;
    logic                     rx_busy;
    logic [3:0]               rx_bits;
    logic [`PERIPH_WORD-1:0]  rx_cnt;
    logic [7:0]               rx_shift;
    logic [7:0]               rx_data;
    logic                     rx_valid;

    assign hit     = bus.sel && (bus.offset >= BLK_OFF) && (bus.offset < BLK_END);
    assign wr      = hit && bus.write_en;
    assign rel     = bus.offset - BLK_OFF;
    assign reg_sel = reg_sel_e'(rel[1:0]);

    // idle line is high since ones are shifted in behind the frame
    assign tx = tx_shift[0];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_q    <= `UART_DIV_RESET;
            tx_busy  <= 1'b0;
            tx_shift <= '1;
            tx_bits  <= '0;
            tx_cnt   <= '0;
        end
        else
        begin
            if (wr && reg_sel == REG_2)
                div_q <= bus.wdata;
            if (!tx_busy)
            begin
                // data writes while busy are dropped
                if (wr && reg_sel == REG_0)
                begin
                    tx_shift <= {1'b1, bus.wdata, 1'b0};
                    tx_busy  <= 1'b1;
                    tx_bits  <= '0;
                    tx_cnt   <= div_q;
                end
            end
            else if (tx_cnt == '0)
            begin
                tx_cnt   <= div_q;
                tx_shift <= {1'b1, tx_shift[9:1]};
                tx_bits  <= tx_bits + 1'b1;
                if (tx_bits == 4'd9)
                    tx_busy <= 1'b0;
            end
            else
                tx_cnt <= tx_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rx_s1    <= 1'b1;
            rx_s2    <= 1'b1;
            rx_prev  <= 1'b1;
            rx_busy  <= 1'b0;
            rx_bits  <= '0;
            rx_cnt   <= '0;
            rx_valid <= 1'b0;
            irq      <= 1'b0;
        end
        else
        begin
            rx_s1   <= rx;
            rx_s2   <= rx_s1;
            rx_prev <= rx_s2;
            irq     <= 1'b0;
            if (wr && reg_sel == REG_1)
                rx_valid <= 1'b0;
            if (!rx_busy)
            begin
                // falling edge, wait half a bit to land mid start bit
                if (rx_prev && !rx_s2)
                begin
                    rx_busy <= 1'b1;
                    rx_bits <= '0;
                    rx_cnt  <= div_q >> 1;
                end
            end
            else if (rx_cnt == '0)
            begin
                rx_cnt  <= div_q;
                rx_bits <= rx_bits + 1'b1;
                if (rx_bits == 4'd0 && rx_s2)
                    rx_busy <= 1'b0;
                else if (rx_bits == 4'd9)
                begin
                    rx_busy  <= 1'b0;
                    rx_valid <= 1'b1;
                    irq      <= 1'b1;
                end
            end
            else
                rx_cnt <= rx_cnt - 1'b1;
        end
    end

    // payload only
    always_ff @(posedge clk)
    begin
        if (rx_busy && rx_cnt == '0)
        begin
            if (rx_bits != 4'd0 && rx_bits != 4'd9)
                rx_shift <= {rx_s2, rx_shift[7:1]};
            if (rx_bits == 4'd9)
                rx_data <= rx_shift;
        end
    end

    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (reg_sel)
                REG_0:   rdata      = rx_data;
                REG_1:   rdata[1:0] = {rx_valid, tx_busy};
                REG_2:   rdata      = div_q;
                default: rdata      = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/periph_minimal.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Peripheral block for an 8-bit CPU register bus. Decodes the address
// window, hands each peripheral a local offset and merges read data.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module periph_minimal (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      enable,
    input  logic [`PERIPH_ADDR_W-1:0] addr,
    input  logic [`PERIPH_WORD-1:0]   data_in,
    output logic [`PERIPH_WORD-1:0]   data_out,
    input  logic                      write_en,
    output logic [2:0]                ext_int,
    input  logic [15:0]               gpi,
    output logic [15:0]               gpo,
    input  logic                      rx,
    output logic                      tx
);

    localparam logic [`PERIPH_ADDR_W-1:0] WIN_BASE = `PERIPH_BASE;
    localparam logic [`PERIPH_ADDR_W-1:0] WIN_END  = `PERIPH_BASE + `PERIPH_TOTAL;

    logic                      in_window;
    logic [`PERIPH_ADDR_W-1:0] addr_rel;
    logic [`PERIPH_WORD-1:0]   rdata_exti;
    logic [`PERIPH_WORD-1:0]   rdata_gpio;
    logic [`PERIPH_WORD-1:0]   rdata_timer;
    logic [`PERIPH_WORD-1:0]   rdata_uart;
    logic                      gpio_irq;
    logic                      timer_irq;
    logic                      uart_irq;

    periph_bus_if bus ();

    // window check and local offset
    assign in_window = enable && (addr >= WIN_BASE) && (addr < WIN_END);
    assign addr_rel  = addr - WIN_BASE;

    assign bus.sel      = in_window;
    assign bus.offset   = addr_rel[`PERIPH_OFF_W-1:0];
    assign bus.wdata    = data_in;
    assign bus.write_en = write_en;

    // unselected blocks return zero
    assign data_out = rdata_exti | rdata_gpio | rdata_timer | rdata_uart;

    periph_exti exti_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus.peripheral),
        .rdata     (rdata_exti),
        .gpio_irq  (gpio_irq),
        .timer_irq (timer_irq),
        .uart_irq  (uart_irq),
        .ext_int   (ext_int)
    );

    periph_gpio gpio_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.peripheral),
        .rdata (rdata_gpio),
        .irq   (gpio_irq),
        .gpi   (gpi),
        .gpo   (gpo)
    );

    periph_timer timer_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.peripheral),
        .rdata (rdata_timer),
        .irq   (timer_irq)
    );

    periph_uart uart_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.peripheral),
        .rdata (rdata_uart),
        .irq   (uart_irq),
        .rx    (rx),
        .tx    (tx)
    );

endmodule

`default_nettype wire

/* verification/periph_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on address decode, interrupt masking and the
// idle uart line. Bound into the peripheral top level.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "periph_params.svh"

module periph_asserts (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      enable,
    input logic [`PERIPH_ADDR_W-1:0] addr,
    input logic [`PERIPH_WORD-1:0]   data_out,
    input logic [2:0]                ext_int,
    input logic [2:0]                mask,
    input logic                      tx,
    input logic                      tx_busy
);

    localparam logic [`PERIPH_ADDR_W-1:0] WIN_BASE = `PERIPH_BASE;
    localparam logic [`PERIPH_ADDR_W-1:0] WIN_END  = `PERIPH_BASE + `PERIPH_TOTAL;

    logic in_window;

    assign in_window = enable && (addr >= WIN_BASE) && (addr < WIN_END);

    window_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (!in_window) |-> (data_out == '0))
        else $error("read data driven outside the register window");

    // masked sources never reach the cpu
    masked_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (mask == 3'b000) |-> (ext_int == 3'b000))
        else $error("interrupt line active with every source masked");

    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        (!tx_busy) |-> tx)
        else $error("tx line low while the transmitter is idle");

endmodule

bind periph_minimal periph_asserts asserts_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .enable   (enable),
    .addr     (addr),
    .data_out (data_out),
    .ext_int  (ext_int),
    .mask     (exti_inst.mask_q),
    .tx       (tx),
    .tx_busy  (uart_inst.tx_busy)
);

`default_nettype wire

/* verification/periph_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the peripheral block. Replays bus operations from the
// stimulus file against the DUT, with tx looped back into rx.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module periph_tb;

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic [7:0]  addr;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic        write_en;
    logic [2:0]  ext_int;
    logic [15:0] gpi;
    logic [15:0] gpo;
    wire         serial_line;

    int unsigned cycles;
    logic [15:0] gpo_model;

    periph_minimal periph_minimal_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .enable   (enable),
        .addr     (addr),
        .data_in  (data_in),
        .data_out (data_out),
        .write_en (write_en),
        .ext_int  (ext_int),
        .gpi      (gpi),
        .gpo      (gpo),
        .rx       (serial_line),
        .tx       (serial_line)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    // free running cycle count for interval checks
    always @(posedge clk)
        cycles <= cycles + 1;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_eq(input logic [15:0] got, input logic [15:0] exp,
                            input string what);
        if (got !== exp)
        begin
            stop_with_failure($sformatf("FAIL %0t: %s, got %0h, expected %0h",
                                        $time, what, got, exp));
        end
    endtask

    // inputs always change 1 ns after the rising edge
    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
        enable   = 1'b1;
        write_en = 1'b1;
        addr     = a;
        data_in  = d;
        next_cycle();
        enable   = 1'b0;
        write_en = 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] a, output logic [7:0] d);
        enable   = 1'b1;
        write_en = 1'b0;
        addr     = a;
        #2;
        d = data_out;
        next_cycle();
        enable = 1'b0;
    endtask

    task automatic wait_irq(input int bit_idx, input int limit);
        int n;
        n = 0;
        while (!ext_int[bit_idx] && n < limit)
        begin
            next_cycle();
            n++;
        end
        if (!ext_int[bit_idx])
            stop_with_failure($sformatf("timed out waiting for interrupt on ext_int bit %0d",
                                        bit_idx));
    endtask

    // clear, catch one rise, clear again, catch the next
    task automatic measure_period(input int bit_idx, input int limit, input logic [15:0] exp);
        int unsigned t0;
        int unsigned t1;
        logic [7:0]  clr;
        clr = 8'h01 << bit_idx;
        bus_write(8'hEF, clr);
        wait_irq(bit_idx, limit);
        t0 = cycles;
        bus_write(8'hEF, clr);
        wait_irq(bit_idx, limit);
        t1 = cycles;
        check_eq(16'(t1 - t0), exp, "timer flag interval");
    endtask

    task automatic gpo_pattern(input logic [7:0] a);
        logic [7:0] pat;
        logic [7:0] rd;
        pat = 8'($urandom);
        bus_write(a, pat);
        if (a[0])
            gpo_model[15:8] = pat;
        else
            gpo_model[7:0] = pat;
        bus_read(a, rd);
        check_eq({8'h00, rd}, {8'h00, pat}, "gpo byte read-back");
        check_eq(gpo, gpo_model, "gpo pins");
    endtask

    task automatic run_op(input logic [7:0] op, input logic [31:0] a,
                          input logic [31:0] d, input logic [31:0] e);
        logic [7:0] rd;
        case (op)
            "W": bus_write(a[7:0], d[7:0]);
            "R":
            begin
                bus_read(a[7:0], rd);
                check_eq({8'h00, rd}, e[15:0], $sformatf("read of address %02h", a[7:0]));
            end
            "G": gpi = d[15:0];
            "C": repeat (d) next_cycle();
            "I": wait_irq(a, d);
            "X": check_eq({13'd0, ext_int}, e[15:0], "ext_int lines");
            "O": check_eq(gpo, e[15:0], "gpo pins");
            "P": gpo_pattern(a[7:0]);
            "M": measure_period(a, d, e[15:0]);
            default: stop_with_failure($sformatf("unknown stimulus operation %s", op));
        endcase
    endtask

    initial
    begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_exp;

        void'($urandom(91));
        gpo_model = '0;
        rst_n     = 1'b0;
        enable    = 1'b0;
        write_en  = 1'b0;
        addr      = '0;
        data_in   = '0;
        gpi       = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        fd = $fopen("verification/periph_stimulus.txt", "r");
        if (fd == 0)
            stop_with_failure("could not open verification/periph_stimulus.txt");
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            // skip blank and comment lines
            if (line.len() > 1 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%s %h %h %h", op, f_addr, f_data, f_exp);
                if (n != 4)
                    stop_with_failure({"malformed stimulus line: ", line});
                run_op(op, f_addr, f_data, f_exp);
            end
        end
        $fclose(fd);
        next_cycle();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/periph_stimulus.txt */
# columns: op addr data expect, all hex, unused fields are 0
# ops: W write, R read-check, G set gpi, C idle cycles, I wait ext_int bit (data = limit)
# X check ext_int, O check gpo, P random gpo byte, M timer flag interval (data = limit)
# reset values
R EE 0 00
R EF 0 00
R F0 0 00
R F1 0 00
R F6 0 00
R F8 0 00
O 0 0 0000
X 0 0 0
# outside the window
R ED 0 00
R FA 0 00
W ED FF 0
W FA FF 0
W 00 FF 0
R EE 0 00
R F9 0 04
O 0 0 0000
P F0 0 0
P F1 0 0
P F0 0 0
# gpio input and change interrupt
W EE 01 0
G 0 A5C3 0
I 0 10 0
C 0 3 0
R F2 0 C3
R F3 0 A5
R EF 0 01
X 0 0 1
W EF 01 0
X 0 0 0
R EF 0 00
# timer, reload 3 and prescale 1
W F4 03 0
W F5 01 0
W EE 02 0
W F6 01 0
I 1 0C 0
M 1 10 8
W F6 00 0
W EF 02 0
X 0 0 0
# uart loopback, divisor 3
W F9 03 0
W EE 04 0
W F7 5A 0
W F7 FF 0
R F8 0 01
I 2 60 0
R F8 0 02
R F7 0 5A
X 0 0 4
W F8 00 0
R F8 0 00
W EF 04 0
X 0 0 0

/* tb.f */
+incdir+include
rtl/periph_pkg.sv
rtl/periph_bus_if.sv
rtl/periph_exti.sv
rtl/periph_gpio.sv
rtl/periph_timer.sv
rtl/periph_uart.sv
rtl/periph_minimal.sv
verification/periph_asserts.sv
verification/periph_tb.sv

/* Makefile */
# Verilator build and run of the peripheral block testbench

VERILATOR ?= verilator
TOP       ?= periph_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
